//--- vlog.f
icache_cfg_pkg.sv
icache_msg_pkg.sv
tag_port_if.sv
icache_array.sv
icache_tag_arb.sv
icache_maint.sv
icache_repl.sv
icache_ctrl.sv
icache_top.sv
icache_checker.sv
tb_icache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the instruction cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_icache \
  || { echo "compile failed"; exit 1; }
./obj_dir/Vtb_icache +verilator+error+limit+100 2>&1 | tee "$LOG"
grep -q -- '>>> FAIL' "$LOG" && { echo "simulation failed"; exit 1; }
grep -q -- '>>> PASS' "$LOG" && echo "simulation passed" \
  || { echo "simulation ended without a result"; exit 1; }

//--- tb_icache.sv
// testbench of the instruction cache with memory responder and line presence model
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int unsigned N_RAND  = 240;
  // directed requests plus the random phase
  localparam int unsigned N_REQ   = N_RAND + 64;
  localparam int unsigned N_SWEEP = 8;
  localparam int unsigned TIMEOUT = N_REQ * 20 + N_SWEEP * (icache_cfg_pkg::NUM_SETS + 4);
  localparam int unsigned N_TAGS  = 8;
  localparam icache_cfg_pkg::word_t WORD_MULT = 32'h9E37_79B9;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       flush_i;
  logic                       fetch_req_i;
  icache_cfg_pkg::paddr_t     fetch_addr_i;
  logic                       fetch_ready_o;
  logic                       fetch_valid_o;
  icache_cfg_pkg::word_t      fetch_data_o;
  icache_cfg_pkg::paddr_t     fetch_addr_o;
  logic                       mem_req_o;
  icache_cfg_pkg::paddr_t     mem_paddr_o;
  logic                       mem_ack_i;
  logic                       mem_rtrn_vld_i;
  icache_msg_pkg::rtrn_kind_e mem_rtrn_kind_i;
  icache_msg_pkg::line_t      mem_rtrn_data_i;
  icache_cfg_pkg::set_idx_t   mem_inv_set_i;
  logic                       miss_o;
  logic                       busy_o;

  // reference model, one present bit per line
  bit present [N_TAGS][icache_cfg_pkg::NUM_SETS];
  bit uncertain [icache_cfg_pkg::NUM_SETS];
  icache_cfg_pkg::paddr_t exp_q [$];
  icache_cfg_pkg::set_idx_t inv_q [$];

  icache_top i_icache_top (
    .clk_i, .rst_ni, .flush_i, .fetch_req_i, .fetch_addr_i, .fetch_ready_o,
    .fetch_valid_o, .fetch_data_o, .fetch_addr_o, .mem_req_o, .mem_paddr_o, .mem_ack_i,
    .mem_rtrn_vld_i, .mem_rtrn_kind_i, .mem_rtrn_data_i, .mem_inv_set_i, .miss_o, .busy_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // memory contents, word address times a constant
  function automatic icache_cfg_pkg::word_t mem_word(input icache_cfg_pkg::paddr_t addr);
    return (addr >> 2) * WORD_MULT;
  endfunction

  function automatic icache_cfg_pkg::paddr_t make_addr(input int unsigned tag,
      input int unsigned set, input int unsigned word);
    return icache_cfg_pkg::paddr_t'((tag << 8) | (set << 4) | (word << 2));
  endfunction

  function automatic int unsigned lines_in_set(input int unsigned set);
    int unsigned n;
    n = 0;
    for (int unsigned t = 0; t < N_TAGS; t++) begin
      if (present[t][set]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  initial begin : watchdog
    repeat (TIMEOUT) @(posedge clk_i);
    stop_on_error($sformatf("timeout, run did not end within %0d cycles", TIMEOUT));
  end

  //////////////////////////////////////////////////////////////////////
  // memory responder, fills and injected invalidations
  //////////////////////////////////////////////////////////////////////

  initial begin : responder
    int unsigned delay;
    icache_msg_pkg::line_t line;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_kind_i = icache_msg_pkg::IFILL_ACK;
    mem_rtrn_data_i = '0;
    mem_inv_set_i   = '0;
    forever begin
      @(posedge clk_i);
      if (rst_ni && mem_req_o) begin
        repeat ($urandom % 4) @(posedge clk_i);
        mem_ack_i <= 1'b1;
        @(posedge clk_i);
        mem_ack_i <= 1'b0;
        delay = 1 + $urandom % 4;
        repeat (delay - 1) @(posedge clk_i);
        for (int w = 0; w < 4; w++) begin
          line[w*32 +: 32] = mem_word(mem_paddr_o + icache_cfg_pkg::paddr_t'(4 * w));
        end
        mem_rtrn_kind_i <= icache_msg_pkg::IFILL_ACK;
        mem_rtrn_data_i <= line;
        mem_rtrn_vld_i  <= 1'b1;
        @(posedge clk_i);
        mem_rtrn_vld_i  <= 1'b0;
      end else if (inv_q.size() != 0) begin
        // only sent while no line is outstanding
        mem_rtrn_kind_i <= icache_msg_pkg::INV_REQ;
        mem_inv_set_i   <= inv_q[0];
        mem_rtrn_vld_i  <= 1'b1;
        @(posedge clk_i);
        mem_rtrn_vld_i  <= 1'b0;
        void'(inv_q.pop_front());
      end
    end
  end

  // every answer against the oldest accepted request
  always @(posedge clk_i) begin : out_monitor
    icache_cfg_pkg::paddr_t exp_addr;
    if (rst_ni && fetch_valid_o) begin
      assert (exp_q.size() != 0)
        else stop_on_error("fetch_valid_o came without an accepted request");
      exp_addr = exp_q.pop_front();
      assert (fetch_addr_o == exp_addr && fetch_data_o == mem_word(exp_addr))
        else stop_on_error($sformatf("Mismatch at %0t ns: got %h/%h, expected %h/%h", $time,
            fetch_addr_o, fetch_data_o, exp_addr, mem_word(exp_addr)));
    end
  end

  task automatic wait_idle();
    while (busy_o) begin
      @(posedge clk_i);
    end
  endtask

  // single fetch, miss and latency checked against the model
  task automatic fetch_word(input icache_cfg_pkg::paddr_t addr);
    int unsigned tag;
    int unsigned set;
    int unsigned lat;
    int unsigned misses;
    bit absent;
    tag    = addr >> 8;
    set    = (addr >> 4) & 32'hF;
    absent = !present[tag][set];
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= addr;
    do @(posedge clk_i); while (!fetch_ready_o);
    exp_q.push_back(addr);
    fetch_req_i <= 1'b0;
    lat    = 0;
    misses = 0;
    do begin
      @(posedge clk_i);
      lat++;
      if (miss_o) begin
        misses++;
      end
    end while (!fetch_valid_o);
    if (!uncertain[set]) begin
      assert (misses == (absent ? 1 : 0))
        else stop_on_error($sformatf("Mismatch at %0t ns: %h gave %0d misses, model absent %0b",
            $time, addr, misses, absent));
      assert (absent || lat == 1)
        else stop_on_error($sformatf("Mismatch at %0t ns: hit on %h took %0d cycles",
            $time, addr, lat));
    end
    if (absent) begin
      present[tag][set] = 1'b1;
      // a fifth tag evicts a way chosen by the LFSR
      if (lines_in_set(set) > icache_cfg_pkg::NUM_WAYS) begin
        uncertain[set] = 1'b1;
      end
    end
  endtask

  // back-to-back hits, one answer per cycle
  task automatic stream_hits(input icache_cfg_pkg::paddr_t addrs [$]);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= addrs[0];
    for (int i = 0; i < addrs.size(); i++) begin
      @(posedge clk_i);
      assert (fetch_ready_o && !miss_o)
        else stop_on_error("back-to-back hit was not accepted at once");
      assert (i == 0 || fetch_valid_o)
        else stop_on_error($sformatf("Mismatch at %0t ns: no answer one cycle after a hit",
            $time));
      exp_q.push_back(addrs[i]);
      if (i + 1 < addrs.size()) begin
        fetch_addr_i <= addrs[i + 1];
      end else begin
        fetch_req_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    assert (fetch_valid_o) else stop_on_error("last hit of the stream gave no answer");
  endtask

  task automatic flush_cache();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(posedge clk_i);
    assert (busy_o && !fetch_ready_o)
      else stop_on_error("busy_o or fetch_ready_o did not follow flush_i");
    wait_idle();
    for (int unsigned s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
      uncertain[s] = 1'b0;
      for (int unsigned t = 0; t < N_TAGS; t++) begin
        present[t][s] = 1'b0;
      end
    end
  endtask

  task automatic invalidate_set(input int unsigned set);
    inv_q.push_back(icache_cfg_pkg::set_idx_t'(set));
    while (inv_q.size() != 0) begin
      @(posedge clk_i);
    end
    uncertain[set] = 1'b0;
    for (int unsigned t = 0; t < N_TAGS; t++) begin
      present[t][set] = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests, then random fetches
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    icache_cfg_pkg::paddr_t addrs [$];
    void'($urandom(44484));
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // initial sweep
    wait_idle();
    for (int unsigned s = 0; s < 8; s++) begin
      fetch_word(make_addr(1, s, 0));
      fetch_word(make_addr(1, s, 3));
    end
    for (int unsigned s = 0; s < 4; s++) begin
      for (int unsigned w = 0; w < 4; w++) begin
        addrs.push_back(make_addr(1, s, w));
      end
    end
    stream_hits(addrs);
    // set 2 is gone, set 3 stays
    invalidate_set(2);
    fetch_word(make_addr(1, 2, 1));
    fetch_word(make_addr(1, 3, 1));
    // eight tags in set 9 go through the random victim
    for (int unsigned r = 0; r < 2; r++) begin
      for (int unsigned t = 0; t < N_TAGS; t++) begin
        fetch_word(make_addr(t, 9, r));
      end
    end
    flush_cache();
    for (int unsigned s = 0; s < 8; s++) begin
      fetch_word(make_addr(1, s, 2));
    end
    for (int unsigned n = 0; n < N_RAND; n++) begin
      if (n % 80 == 79) begin
        flush_cache();
      end else if ($urandom % 12 == 0) begin
        invalidate_set($urandom % 16);
      end
      fetch_word(make_addr($urandom % 5, $urandom % 16, $urandom % 4));
    end
    repeat (2) @(posedge clk_i);
    if (i_icache_top.i_checker.fail_cnt != 0 || exp_q.size() != 0) begin
      $display("%0d checker assertions failed, %0d requests unanswered",
          i_icache_top.i_checker.fail_cnt, exp_q.size());
      $display(">>> FAIL");
      $fatal(1, "run ended with errors");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- icache_checker.sv
// protocol checker on the instruction cache ports, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module icache_checker (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   fetch_ready_i,
  input logic                   fetch_valid_i,
  input logic                   mem_req_i,
  input icache_cfg_pkg::paddr_t mem_paddr_i,
  input logic                   mem_ack_i,
  input logic                   miss_i,
  input logic                   busy_i,
  input logic                   sweeping_i,
  input logic                   ctrl_idle_i
);

  // number of failed assertions
  int unsigned fail_cnt = 0;

  // line request stays up with a fixed address until acknowledged
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_paddr_i))
    else begin
      fail_cnt++;
      $error("mem_req_o dropped or mem_paddr_o changed before mem_ack_i");
    end

  // a miss is counted in the ack cycle only
  miss_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
      miss_i |-> mem_ack_i && mem_req_i)
    else begin
      fail_cnt++;
      $error("miss_o seen without mem_ack_i");
    end

  // an idle FSM under a sweep never answers
  idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
      busy_i && ctrl_idle_i |-> !fetch_valid_i)
    else begin
      fail_cnt++;
      $error("fetch_valid_o while busy_o is high and the FSM is idle");
    end

  sweep_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
      sweeping_i |-> !fetch_ready_i)
    else begin
      fail_cnt++;
      $error("fetch_ready_o high during a flush sweep");
    end

  // outputs come out of reset quiet
  reset_quiet: assert property (@(posedge clk_i)
      $rose(rst_ni) |-> !fetch_valid_i && !mem_req_i && !miss_i)
    else begin
      fail_cnt++;
      $error("fetch_valid_o, mem_req_o or miss_o high right after reset");
    end

endmodule

bind icache_top icache_checker i_checker (
  .clk_i,
  .rst_ni,
  .fetch_ready_i (fetch_ready_o),
  .fetch_valid_i (fetch_valid_o),
  .mem_req_i     (mem_req_o),
  .mem_paddr_i   (mem_paddr_o),
  .mem_ack_i,
  .miss_i        (miss_o),
  .busy_i        (busy_o),
  .sweeping_i    (sweeping),
  .ctrl_idle_i   (i_ctrl.state_q == 2'd0)
);

`default_nettype wire

//--- icache_top.sv
// set-associative instruction cache, all blocks wired to plain ports
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       fetch_req_i,
  input  icache_cfg_pkg::paddr_t     fetch_addr_i,
  output logic                       fetch_ready_o,
  output logic                       fetch_valid_o,
  output icache_cfg_pkg::word_t      fetch_data_o,
  output icache_cfg_pkg::paddr_t     fetch_addr_o,
  output logic                       mem_req_o,
  output icache_cfg_pkg::paddr_t     mem_paddr_o,
  input  logic                       mem_ack_i,
  input  logic                       mem_rtrn_vld_i,
  input  icache_msg_pkg::rtrn_kind_e mem_rtrn_kind_i,
  input  icache_msg_pkg::line_t      mem_rtrn_data_i,
  input  icache_cfg_pkg::set_idx_t   mem_inv_set_i,
  output logic                       miss_o,
  output logic                       busy_o
);

  tag_port_if maint_port ();
  tag_port_if ctrl_port ();

  icache_cfg_pkg::way_mask_t  tag_req;
  logic                       tag_we;
  icache_cfg_pkg::set_idx_t   tag_addr;
  icache_cfg_pkg::tag_entry_t tag_wdata;
  icache_cfg_pkg::tag_entry_t tag_rdata [icache_cfg_pkg::NUM_WAYS-1:0];
  icache_cfg_pkg::way_mask_t  tag_valid;
  icache_cfg_pkg::way_mask_t  data_req;
  logic                       data_we;
  icache_cfg_pkg::set_idx_t   data_addr;
  icache_msg_pkg::line_t      data_rdata [icache_cfg_pkg::NUM_WAYS-1:0];
  icache_cfg_pkg::way_mask_t  victim;
  logic                       capture;
  logic                       fill;
  logic                       sweeping;

  for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : gen_valid
    assign tag_valid[w] = tag_rdata[w].valid;
  end

  icache_ctrl i_ctrl (
    .clk_i, .rst_ni, .fetch_req_i, .fetch_addr_i, .fetch_ready_o, .fetch_valid_o,
    .fetch_data_o, .fetch_addr_o, .mem_req_o, .mem_paddr_o, .mem_ack_i,
    .mem_rtrn_vld_i, .mem_rtrn_kind_i, .mem_rtrn_data_i,
    .port         (ctrl_port.peer),
    .tag_rdata_i  (tag_rdata),
    .data_req_o   (data_req),
    .data_we_o    (data_we),
    .data_addr_o  (data_addr),
    .data_rdata_i (data_rdata),
    .victim_i     (victim),
    .capture_o    (capture),
    .fill_o       (fill),
    .sweeping_i   (sweeping),
    .miss_o, .busy_o
  );

  icache_maint i_maint (
    .clk_i, .rst_ni, .flush_i, .mem_rtrn_vld_i, .mem_rtrn_kind_i, .mem_inv_set_i,
    .port       (maint_port.peer),
    .sweeping_o (sweeping)
  );

  icache_tag_arb i_arb (
    .clk_i, .rst_ni,
    .maint       (maint_port.arb),
    .ctrl        (ctrl_port.arb),
    .arr_req_o   (tag_req),
    .arr_we_o    (tag_we),
    .arr_addr_o  (tag_addr),
    .arr_wdata_o (tag_wdata)
  );

  icache_repl i_repl (
    .clk_i, .rst_ni,
    .valid_i   (tag_valid),
    .capture_i (capture),
    .fill_i    (fill),
    .victim_o  (victim)
  );

  icache_array #(.entry_t(icache_cfg_pkg::tag_entry_t)) i_tag_array (
    .clk_i, .rst_ni,
    .req_i   (tag_req),
    .we_i    (tag_we),
    .addr_i  (tag_addr),
    .wdata_i (tag_wdata),
    .rdata_o (tag_rdata)
  );

  // line data comes straight from the return channel
  icache_array #(.entry_t(icache_msg_pkg::line_t)) i_data_array (
    .clk_i, .rst_ni,
    .req_i   (data_req),
    .we_i    (data_we),
    .addr_i  (data_addr),
    .wdata_i (mem_rtrn_data_i),
    .rdata_o (data_rdata)
  );

endmodule

`default_nettype wire

//--- icache_ctrl.sv
// fetch FSM with tag compare, word select, miss request and line fill
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       fetch_req_i,
  input  icache_cfg_pkg::paddr_t     fetch_addr_i,
  output logic                       fetch_ready_o,
  output logic                       fetch_valid_o,
  output icache_cfg_pkg::word_t      fetch_data_o,
  output icache_cfg_pkg::paddr_t     fetch_addr_o,
  output logic                       mem_req_o,
  output icache_cfg_pkg::paddr_t     mem_paddr_o,
  input  logic                       mem_ack_i,
  input  logic                       mem_rtrn_vld_i,
  input  icache_msg_pkg::rtrn_kind_e mem_rtrn_kind_i,
  input  icache_msg_pkg::line_t      mem_rtrn_data_i,
  tag_port_if.peer                   port,
  input  icache_cfg_pkg::tag_entry_t tag_rdata_i [icache_cfg_pkg::NUM_WAYS-1:0],
  output icache_cfg_pkg::way_mask_t  data_req_o,
  output logic                       data_we_o,
  output icache_cfg_pkg::set_idx_t   data_addr_o,
  input  icache_msg_pkg::line_t      data_rdata_i [icache_cfg_pkg::NUM_WAYS-1:0],
  input  icache_cfg_pkg::way_mask_t  victim_i,
  output logic                       capture_o,
  output logic                       fill_o,
  input  logic                       sweeping_i,
  output logic                       miss_o,
  output logic                       busy_o
);

  typedef enum logic [1:0] {IDLE, READ, MISS} state_e;

  state_e                    state_q, state_d;
  icache_cfg_pkg::paddr_t    addr_q, addr_d;
  // tag read of addr_q reached the array last cycle
  logic                      rd_ok_q, rd_ok_d;
  // line request still waiting for its ack
  logic                      req_q, req_d;
  icache_cfg_pkg::tag_t      cmp_tag;
  icache_cfg_pkg::way_mask_t hit;
  icache_cfg_pkg::way_idx_t  hit_way;
  logic [icache_cfg_pkg::OFFSET_WIDTH-icache_cfg_pkg::BYTE_SEL_WIDTH-1:0] word_sel;
  logic                      lookup;
  icache_cfg_pkg::paddr_t    lookup_addr;
  logic                      fill;
  logic                      rtrn_fill;

  assign cmp_tag   = addr_q[icache_cfg_pkg::PADDR_WIDTH-1 -: icache_cfg_pkg::TAG_WIDTH];
  assign word_sel  = addr_q[icache_cfg_pkg::OFFSET_WIDTH-1:icache_cfg_pkg::BYTE_SEL_WIDTH];
  assign rtrn_fill = mem_rtrn_vld_i && (mem_rtrn_kind_i == icache_msg_pkg::IFILL_ACK);

  //////////////////////////////////////////////////////////////////////
  // tag compare and word select
  //////////////////////////////////////////////////////////////////////

  for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : gen_cmp
    assign hit[w] = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == cmp_tag);
  end

  // lowest hitting way
  always_comb begin
    hit_way = '0;
    for (int w = icache_cfg_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hit[w]) begin
        hit_way = icache_cfg_pkg::way_idx_t'(w);
      end
    end
  end

  // returned line bypasses the array during a miss
  assign fetch_data_o = (state_q == MISS) ?
      mem_rtrn_data_i[word_sel*icache_cfg_pkg::WORD_WIDTH +: icache_cfg_pkg::WORD_WIDTH] :
      data_rdata_i[hit_way][word_sel*icache_cfg_pkg::WORD_WIDTH +: icache_cfg_pkg::WORD_WIDTH];
  assign fetch_addr_o = addr_q;
  assign mem_paddr_o  = {addr_q[icache_cfg_pkg::PADDR_WIDTH-1:icache_cfg_pkg::OFFSET_WIDTH],
                         {icache_cfg_pkg::OFFSET_WIDTH{1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // fetch FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    addr_d        = addr_q;
    req_d         = req_q;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    capture_o     = 1'b0;
    lookup        = 1'b0;
    lookup_addr   = addr_q;
    fill          = 1'b0;
    unique case (state_q)
      IDLE: begin
        fetch_ready_o = !sweeping_i;
        if (fetch_req_i && !sweeping_i) begin
          lookup      = 1'b1;
          lookup_addr = fetch_addr_i;
          addr_d      = fetch_addr_i;
          state_d     = READ;
        end
      end
      READ: begin
        if (!rd_ok_q) begin
          // array was taken, read again
          lookup = 1'b1;
        end else if (|hit) begin
          fetch_valid_o = 1'b1;
          fetch_ready_o = !sweeping_i;
          state_d       = IDLE;
          // next lookup overlaps this compare
          if (fetch_req_i && !sweeping_i) begin
            lookup      = 1'b1;
            lookup_addr = fetch_addr_i;
            addr_d      = fetch_addr_i;
            state_d     = READ;
          end
        end else begin
          capture_o = 1'b1;
          mem_req_o = 1'b1;
          miss_o    = mem_ack_i;
          req_d     = !mem_ack_i;
          state_d   = MISS;
        end
      end
      MISS: begin
        mem_req_o = req_q;
        miss_o    = req_q & mem_ack_i;
        if (mem_ack_i) begin
          req_d = 1'b0;
        end
        if (rtrn_fill) begin
          fetch_valid_o = 1'b1;
          fill          = 1'b1;
          state_d       = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign rd_ok_d = lookup & port.gnt;
  assign fill_o  = fill;
  assign busy_o  = (state_q != IDLE) | sweeping_i;

  // reads cover all ways, a fill writes the victim only
  assign port.req      = lookup | fill;
  assign port.we       = fill;
  assign port.set      = lookup_addr[icache_cfg_pkg::OFFSET_WIDTH +: icache_cfg_pkg::INDEX_WIDTH];
  assign port.way_mask = fill ? victim_i : '1;
  assign port.wtag     = cmp_tag;
  assign port.wvalid   = 1'b1;
  assign port.lock     = (state_q != IDLE);

  assign data_req_o  = lookup ? '1 : (fill ? victim_i : '0);
  assign data_we_o   = fill;
  assign data_addr_o = port.set;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      rd_ok_q <= 1'b0;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      rd_ok_q <= rd_ok_d;
      req_q   <= req_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
  end

endmodule

`default_nettype wire

//--- icache_repl.sv
// victim way selection, first invalid way or an LFSR pick when all are valid
`timescale 1ns/1ps
`default_nettype none

module icache_repl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  icache_cfg_pkg::way_mask_t valid_i,
  input  logic                      capture_i,
  input  logic                      fill_i,
  output icache_cfg_pkg::way_mask_t victim_o
);

  logic [icache_cfg_pkg::LFSR_WIDTH-1:0] lfsr_q;
  logic                                  lfsr_fb;
  icache_cfg_pkg::way_mask_t             first_inv;
  icache_cfg_pkg::way_mask_t             rnd_way;
  logic                                  all_valid;
  logic                                  all_valid_q;
  icache_cfg_pkg::way_mask_t             victim_q;

  // lowest invalid way wins
  always_comb begin
    first_inv = '0;
    for (int w = icache_cfg_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        first_inv = icache_cfg_pkg::way_mask_t'(1) << w;
      end
    end
  end

  assign all_valid = &valid_i;
  assign rnd_way   = icache_cfg_pkg::way_mask_t'(1) << icache_cfg_pkg::way_idx_t'(lfsr_q);
  // taps 8,6,5,4 give a maximal sequence
  assign lfsr_fb   = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  assign victim_o  = victim_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q      <= '1;
      all_valid_q <= 1'b0;
      victim_q    <= '0;
    end else begin
      // decision taken in the compare cycle
      if (capture_i) begin
        victim_q    <= all_valid ? rnd_way : first_inv;
        all_valid_q <= all_valid;
      end
      // only random replacements move the sequence on
      if (fill_i && all_valid_q) begin
        lfsr_q <= {lfsr_q[icache_cfg_pkg::LFSR_WIDTH-2:0], lfsr_fb};
      end
    end
  end

endmodule

`default_nettype wire

//--- icache_maint.sv
// flush sweep over all sets and set invalidations from the return channel
`timescale 1ns/1ps
`default_nettype none

module icache_maint (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       mem_rtrn_vld_i,
  input  icache_msg_pkg::rtrn_kind_e mem_rtrn_kind_i,
  input  icache_cfg_pkg::set_idx_t   mem_inv_set_i,
  tag_port_if.peer                   port,
  output logic                       sweeping_o
);

  logic                     pending_q;
  icache_cfg_pkg::set_idx_t cnt_q;
  logic                     inv;
  logic                     step;
  logic                     last;

  assign inv  = mem_rtrn_vld_i && (mem_rtrn_kind_i == icache_msg_pkg::INV_REQ);
  // an invalidation borrows the grant, the sweep resumes afterwards
  assign step = pending_q & port.gnt & ~inv;
  assign last = (cnt_q == icache_cfg_pkg::set_idx_t'(icache_cfg_pkg::NUM_SETS - 1));

  // both requests clear every way of one set
  assign port.req      = inv | pending_q;
  assign port.we       = 1'b1;
  assign port.set      = inv ? mem_inv_set_i : cnt_q;
  assign port.way_mask = '1;
  assign port.wtag     = '0;
  assign port.wvalid   = 1'b0;
  assign port.lock     = inv;

  assign sweeping_o = pending_q;

  // pending starts set so the cache sweeps after reset
  // a new flush restarts the sweep at set 0
  // the counter wraps back to set 0 on the last step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b1;
      cnt_q     <= '0;
    end else begin
      if (flush_i) begin
        cnt_q <= '0;
      end else if (step) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (flush_i) begin
        pending_q <= 1'b1;
      end else if (step && last) begin
        pending_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- icache_tag_arb.sv
// fixed-priority arbiter of maintenance and controller at the tag/valid array
`timescale 1ns/1ps
`default_nettype none

module icache_tag_arb (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  tag_port_if.arb                    maint,
  tag_port_if.arb                    ctrl,
  output icache_cfg_pkg::way_mask_t  arr_req_o,
  output logic                       arr_we_o,
  output icache_cfg_pkg::set_idx_t   arr_addr_o,
  output icache_cfg_pkg::tag_entry_t arr_wdata_o
);

  logic maint_win;
  // a running sweep keeps the array until its request drops
  logic sweep_own_q;

  // maintenance lock marks an invalidation, which never waits
  // a sweep only starts while the controller is unlocked
  assign maint_win = maint.req & (maint.lock | sweep_own_q | ~ctrl.lock);
  assign maint.gnt = maint_win;
  assign ctrl.gnt  = ctrl.req & ~maint_win;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sweep_own_q <= 1'b0;
    end else begin
      sweep_own_q <= maint.req & (sweep_own_q | (maint_win & ~maint.lock));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // winner command to the array
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (maint_win) begin
      arr_req_o         = maint.way_mask;
      arr_we_o          = maint.we;
      arr_addr_o        = maint.set;
      arr_wdata_o.valid = maint.wvalid;
      arr_wdata_o.tag   = maint.wtag;
    end else begin
      arr_req_o         = ctrl.req ? ctrl.way_mask : '0;
      arr_we_o          = ctrl.req & ctrl.we;
      arr_addr_o        = ctrl.set;
      arr_wdata_o.valid = ctrl.wvalid;
      arr_wdata_o.tag   = ctrl.wtag;
    end
  end

endmodule

`default_nettype wire

//--- icache_array.sv
// per-way set-indexed memory with one-cycle read latency, for tags or lines
`timescale 1ns/1ps
`default_nettype none

module icache_array #(
  parameter type entry_t = logic
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  icache_cfg_pkg::way_mask_t req_i,
  input  logic                      we_i,
  input  icache_cfg_pkg::set_idx_t  addr_i,
  input  entry_t                    wdata_i,
  output entry_t                    rdata_o [icache_cfg_pkg::NUM_WAYS-1:0]
);

  for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : gen_way
    entry_t mem_q [icache_cfg_pkg::NUM_SETS];

    // only the ways selected by the mask take the write
    always_ff @(posedge clk_i) begin
      if (req_i[w] && we_i) begin
        mem_q[addr_i] <= wdata_i;
      end
    end

    // read data holds until the next read of this way
    // zero after reset reads as an invalid tag entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rdata_o[w] <= '0;
      end else if (req_i[w] && !we_i) begin
        rdata_o[w] <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- tag_port_if.sv
// access of one peer to the shared tag/valid array through the arbiter
`timescale 1ns/1ps
`default_nettype none

interface tag_port_if;

  // command, held by the peer
  logic                      req;
  logic                      we;
  icache_cfg_pkg::set_idx_t  set;
  icache_cfg_pkg::way_mask_t way_mask;
  icache_cfg_pkg::tag_t      wtag;
  logic                      wvalid;
  // peer asks to keep the array for itself
  logic                      lock;
  // command reaches the array this cycle
  logic                      gnt;

  modport peer (output req, we, set, way_mask, wtag, wvalid, lock, input gnt);
  modport arb (input req, we, set, way_mask, wtag, wvalid, lock, output gnt);

endinterface

`default_nettype wire

//--- icache_msg_pkg.sv
// memory return channel of the instruction cache, message kinds and line type
`default_nettype none

package icache_msg_pkg;

  // a full line travels in one beat
  localparam int unsigned LINE_WIDTH = icache_cfg_pkg::LINE_BYTES * 8;

  typedef logic [LINE_WIDTH-1:0] line_t;

  // return kinds share the channel, so fill and invalidation never coincide
  typedef enum logic {
    IFILL_ACK = 1'b0,
    INV_REQ   = 1'b1
  } rtrn_kind_e;

endpackage

`default_nettype wire

//--- icache_cfg_pkg.sv
// instruction cache geometry with sizes, widths and address field types
`default_nettype none

package icache_cfg_pkg;

  // organisation
  localparam int unsigned NUM_WAYS    = 4;
  localparam int unsigned NUM_SETS    = 16;
  localparam int unsigned LINE_BYTES  = 16;
  localparam int unsigned WORD_WIDTH  = 32;
  localparam int unsigned PADDR_WIDTH = 32;

  // address split into tag, set index and byte offset
  localparam int unsigned INDEX_WIDTH    = $clog2(NUM_SETS);
  localparam int unsigned OFFSET_WIDTH   = $clog2(LINE_BYTES);
  localparam int unsigned TAG_WIDTH      = PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int unsigned BYTE_SEL_WIDTH = $clog2(WORD_WIDTH / 8);

  // random replacement
  localparam int unsigned LFSR_WIDTH = 8;

  typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;
  typedef logic [NUM_WAYS-1:0]         way_mask_t;
  typedef logic [INDEX_WIDTH-1:0]      set_idx_t;
  typedef logic [TAG_WIDTH-1:0]        tag_t;
  typedef logic [PADDR_WIDTH-1:0]      paddr_t;
  typedef logic [WORD_WIDTH-1:0]       word_t;

  // one tag array entry, valid bit on top
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire
